/* logic/cmd_tx.sv */
`timescale 1ns/1ps

module cmd_tx (
    input  logic                   clk_fast,
    input  logic                   init_resetPulse,
    input  sd_cmd_pkg::sd_strobe_t strobe,
    input  logic                   req_valid,
    input  sd_cmd_pkg::cmd_req_t   req,
    output logic                   ready,
    output logic                   cmd_out,
    output logic                   cmd_oe,
    output logic                   done,
    output sd_cmd_pkg::resp_kind_t finished_kind
);
    import sd_cmd_pkg::*;

    tx_state_t                 state;
    bit_count_t                bit_cnt;
    logic [CRC_COVER_BITS-1:0] shreg;
    logic                      accept;
    logic                      crc_shift;
    crc7_t                     crc;

    assign ready  = (state == TX_IDLE);
    assign accept = req_valid && ready;

    // Covered bits pass through the CRC as they go onto the line
    assign crc_shift = (state == TX_SHIFT) && strobe.drive;

    crc7_gen u_crc (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (accept),
        .shift           (crc_shift),
        .bit_in          (shreg[CRC_COVER_BITS-1]),
        .crc             (crc)
    );

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state         <= TX_IDLE;
            bit_cnt       <= '0;
            cmd_out       <= 1'b1;
            cmd_oe        <= 1'b0;
            done          <= 1'b0;
            finished_kind <= RESP_NONE;
        end else begin
            done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        finished_kind <= req.resp_kind;
                        bit_cnt       <= '0;
                        state         <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (strobe.drive) begin
                        cmd_out <= shreg[CRC_COVER_BITS-1];
                        cmd_oe  <= 1'b1;
                        if (bit_cnt == bit_count_t'(CRC_COVER_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= TX_CRC;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_CRC: begin
                    if (strobe.drive) begin
                        if (bit_cnt == bit_count_t'(CRC_BITS)) begin
                            // End bit follows the last CRC bit
                            cmd_out <= 1'b1;
                            state   <= TX_END;
                        end else begin
                            cmd_out <= crc[CRC_BITS - 1 - int'(bit_cnt)];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_END: begin
                    // Release the line as the end bit period closes
                    if (strobe.drive) begin
                        cmd_oe <= 1'b0;
                        done   <= 1'b1;
                        state  <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Token head, MSB goes out first
    always_ff @(posedge clk_fast) begin
        if (accept) begin
            shreg <= {1'b0, 1'b1, req.index, req.arg};
        end else if (crc_shift) begin
            shreg <= {shreg[CRC_COVER_BITS-2:0], 1'b0};
        end
    end

endmodule

/* logic/crc7_gen.sv */
`timescale 1ns/1ps

module crc7_gen (
    input  logic              clk_fast,
    input  logic              init_resetPulse,
    input  logic              clear,
    input  logic              shift,
    input  logic              bit_in,
    output sd_cmd_pkg::crc7_t crc
);
    import sd_cmd_pkg::*;

    logic feedback;

    // MSB first, new bit meets the top of the register
    assign feedback = bit_in ^ crc[CRC_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC7_POLY : crc7_t'(0));
        end
    end

endmodule

/* logic/resp_rx.sv */
`timescale 1ns/1ps

module resp_rx (
    input  logic                     clk_fast,
    input  logic                     init_resetPulse,
    input  sd_cmd_pkg::sd_strobe_t   strobe,
    input  logic                     tx_done,
    input  sd_cmd_pkg::resp_kind_t   tx_kind,
    input  logic                     cmd_in,
    output logic                     busy,
    output logic                     resp_valid,
    output sd_cmd_pkg::resp_result_t resp_result
);
    import sd_cmd_pkg::*;

    rx_state_t   state;
    bit_count_t  bit_cnt;
    wait_count_t wait_cnt;
    token_t      shreg;
    logic        cmd_in_q;
    logic        arm;
    logic        timed_out;
    logic        capture;
    logic        crc_shift;
    crc7_t       crc;

    assign arm = tx_done && (tx_kind == RESP_48);

    // Busy already in the arming cycle so cmd_ready stays low
    assign busy = (state != RX_IDLE) || arm;

    // Start bit counts as bit 0 of the token
    assign capture = strobe.sample &&
                     (((state == RX_WAIT_START) && !cmd_in_q) || (state == RX_SHIFT));
    assign crc_shift = capture && (bit_cnt < bit_count_t'(CRC_COVER_BITS));

    crc7_gen u_crc (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (arm),
        .shift           (crc_shift),
        .bit_in          (cmd_in_q),
        .crc             (crc)
    );

    // ====================
    // Receive FSM
    // ====================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            wait_cnt   <= '0;
            timed_out  <= 1'b0;
            cmd_in_q   <= 1'b1;
            resp_valid <= 1'b0;
        end else begin
            cmd_in_q   <= cmd_in;
            resp_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (arm) begin
                        bit_cnt   <= '0;
                        wait_cnt  <= '0;
                        timed_out <= 1'b0;
                        state     <= RX_GAP;
                    end
                end
                RX_GAP: begin
                    if (strobe.sample) begin
                        if (bit_cnt == bit_count_t'(RESP_GAP_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= RX_WAIT_START;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_WAIT_START: begin
                    if (strobe.sample) begin
                        if (!cmd_in_q) begin
                            bit_cnt <= bit_count_t'(1);
                            state   <= RX_SHIFT;
                        end else if (wait_cnt == wait_count_t'(RESP_TIMEOUT_BITS - 1)) begin
                            timed_out <= 1'b1;
                            state     <= RX_CHECK;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                RX_SHIFT: begin
                    if (strobe.sample) begin
                        if (bit_cnt == bit_count_t'(CMD_BITS - 1)) begin
                            state <= RX_CHECK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_CHECK: begin
                    resp_valid <= 1'b1;
                    state      <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_fast) begin
        if (capture) begin
            shreg <= {shreg[CMD_BITS-2:0], cmd_in_q};
        end
    end

    // Token: start, tx bit, index[45:40], arg[39:8], crc[7:1], end[0]
    always_ff @(posedge clk_fast) begin
        if (state == RX_CHECK) begin
            if (timed_out) begin
                resp_result         <= '0;
                resp_result.timeout <= 1'b1;
            end else begin
                resp_result.index   <= shreg[45:40];
                resp_result.arg     <= shreg[39:8];
                resp_result.crc_err <= (shreg[7:1] != crc);
                resp_result.end_err <= !shreg[0];
                resp_result.timeout <= 1'b0;
            end
        end
    end

endmodule

/* logic/sd_clk_gen.sv */
`timescale 1ns/1ps

module sd_clk_gen (
    input  logic                   clk_fast,
    input  logic                   init_resetPulse,
    output logic                   sd_clk,
    output sd_cmd_pkg::sd_strobe_t strobe
);
    import sd_cmd_pkg::*;

    logic [DIV_CNT_BITS-1:0] div_cnt;
    logic                    half_edge;
    logic                    wrap_edge;
    logic                    toggle;

    // sd_clk flips at the half period and at the wrap
    assign half_edge = (div_cnt == DIV_CNT_BITS'(SD_CLK_DIV / 2 - 1));
    assign wrap_edge = (div_cnt == DIV_CNT_BITS'(SD_CLK_DIV - 1));
    assign toggle    = half_edge || wrap_edge;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
            strobe  <= '0;
        end else begin
            div_cnt <= wrap_edge ? '0 : div_cnt + 1'b1;
            if (toggle) begin
                sd_clk <= ~sd_clk;
            end
            // Strobes are registered with sd_clk so they share its edge
            strobe.sample <= toggle && !sd_clk;
            strobe.drive  <= toggle && sd_clk;
        end
    end

endmodule

/* logic/sd_cmd_host.sv */
`timescale 1ns/1ps

module sd_cmd_host (
    input  logic                     clk_fast,
    input  logic                     init_resetPulse,
    input  logic                     cmd_valid,
    input  sd_cmd_pkg::cmd_req_t     cmd_req,
    output logic                     cmd_ready,
    output logic                     cmd_done,
    output logic                     resp_valid,
    output sd_cmd_pkg::resp_result_t resp_result,
    output logic                     sd_clk,
    output logic                     sd_cmd_out,
    output logic                     sd_cmd_oe,
    input  logic                     sd_cmd_in
);
    import sd_cmd_pkg::*;

    sd_strobe_t strobe;
    logic       tx_ready;
    resp_kind_t tx_kind;
    logic       rx_busy;

    // A new command waits until any response has been reported
    assign cmd_ready = tx_ready && !rx_busy;

    // ====================
    // Clock generator
    // ====================
    sd_clk_gen u_clk_gen (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .sd_clk          (sd_clk),
        .strobe          (strobe)
    );

    // ====================
    // Command path
    // ====================
    cmd_tx u_cmd_tx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .strobe          (strobe),
        .req_valid       (cmd_valid && !rx_busy),
        .req             (cmd_req),
        .ready           (tx_ready),
        .cmd_out         (sd_cmd_out),
        .cmd_oe          (sd_cmd_oe),
        .done            (cmd_done),
        .finished_kind   (tx_kind)
    );

    // ====================
    // Response path
    // ====================
    resp_rx u_resp_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .strobe          (strobe),
        .tx_done         (cmd_done),
        .tx_kind         (tx_kind),
        .cmd_in          (sd_cmd_in),
        .busy            (rx_busy),
        .resp_valid      (resp_valid),
        .resp_result     (resp_result)
    );

endmodule

/* logic/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // ====================
    // Timing and sizes
    // ====================

    // clk_fast cycles per sd_clk period, must stay even
    localparam int SD_CLK_DIV        = 4;
    localparam int DIV_CNT_BITS      = $clog2(SD_CLK_DIV);
    localparam int CMD_BITS          = 48;
    localparam int CRC_BITS          = 7;
    // Start, transmission bit, index and arg
    localparam int CRC_COVER_BITS    = 40;
    // Idle bits skipped while the line turns around
    localparam int RESP_GAP_BITS     = 2;
    localparam int RESP_TIMEOUT_BITS = 64;

    // ====================
    // Vector types
    // ====================

    typedef logic [5:0]  cmd_index_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;
    typedef logic [47:0] token_t;
    typedef logic [5:0]  bit_count_t;
    typedef logic [6:0]  wait_count_t;

    // Taps of x^7 + x^3 + 1
    localparam crc7_t CRC7_POLY = 7'h09;

    // ====================
    // Enums and structs
    // ====================

    typedef enum logic {RESP_NONE, RESP_48} resp_kind_t;

    typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_CRC, TX_END} tx_state_t;

    typedef enum logic [2:0] {RX_IDLE, RX_GAP, RX_WAIT_START, RX_SHIFT, RX_CHECK} rx_state_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        resp_kind_t resp_kind;
    } cmd_req_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        logic       crc_err;
        logic       end_err;
        logic       timeout;
    } resp_result_t;

    // Drive at the sd_clk fall, sample at the rise
    typedef struct packed {
        logic drive;
        logic sample;
    } sd_strobe_t;

endpackage

/* sd_cmd_host.f */
logic/sd_cmd_pkg.sv
logic/sd_clk_gen.sv
logic/crc7_gen.sv
logic/cmd_tx.sv
logic/resp_rx.sv
logic/sd_cmd_host.sv
verification/sd_card_model.sv
verification/tb_sd_cmd_host.sv

/* verification/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
    input  logic                   sd_clk,
    input  logic                   cmd_line,
    input  logic                   corrupt_crc,
    input  logic                   bad_end,
    input  logic                   silent,
    output logic                   card_out,
    output logic                   card_oe,
    output int                     cmd_count,
    output sd_cmd_pkg::cmd_index_t cap_index,
    output sd_cmd_pkg::cmd_arg_t   cap_arg,
    output logic                   token_ok
);
    import sd_cmd_pkg::*;

    // CRC7 with x^7 + x^3 + 1, MSB of the data first
    function automatic crc7_t token_crc(input logic [CRC_COVER_BITS-1:0] data);
        crc7_t c;
        logic  fb;
        int    i;
        c = '0;
        for (i = CRC_COVER_BITS - 1; i >= 0; i--) begin
            fb = data[i] ^ c[CRC_BITS-1];
            c  = {c[CRC_BITS-2:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // ====================
    // Command capture
    // ====================
    task automatic receive_command();
        token_t tok;
        int     i;
        @(posedge sd_clk);
        while (cmd_line !== 1'b0) begin
            @(posedge sd_clk);
        end
        // The wait above already found the start bit
        tok = '0;
        for (i = 1; i < CMD_BITS; i++) begin
            @(posedge sd_clk);
            tok[CMD_BITS-1-i] = cmd_line;
        end
        cap_index = tok[45:40];
        cap_arg   = tok[39:8];
        token_ok  = (tok[46] == 1'b1) && (tok[0] == 1'b1) &&
                    (tok[7:1] == token_crc(tok[47:8]));
        cmd_count = cmd_count + 1;
    endtask

    // ====================
    // Response
    // ====================
    task automatic send_response();
        token_t tok;
        crc7_t  crc;
        int     delay;
        int     i;
        // Card to host, so the transmission bit is 0
        tok[47:8] = {1'b0, 1'b0, cap_index, ~cap_arg};
        crc = token_crc(tok[47:8]);
        if (corrupt_crc) begin
            crc[0] = ~crc[0];
        end
        tok[7:1] = crc;
        tok[0]   = !bad_end;
        delay    = $urandom_range(20, 2);
        repeat (delay) @(negedge sd_clk);
        for (i = 0; i < CMD_BITS; i++) begin
            @(negedge sd_clk);
            card_oe  = 1'b1;
            card_out = tok[CMD_BITS-1-i];
        end
        @(negedge sd_clk);
        card_oe  = 1'b0;
        card_out = 1'b1;
    endtask

    initial begin
        card_out  = 1'b1;
        card_oe   = 1'b0;
        cmd_count = 0;
        cap_index = '0;
        cap_arg   = '0;
        token_ok  = 1'b0;
        forever begin
            receive_command();
            if (!silent) begin
                send_response();
            end
        end
    end

endmodule

/* verification/tb_sd_cmd_host.sv */
`timescale 1ns/1ps

module tb_sd_cmd_host;
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {FAULT_NONE, CORRUPT_CRC, BAD_END, SILENT} fault_t;

    localparam int CLK_PERIOD_NS = 40;
    localparam int READY_LIMIT  = 1000;
    localparam int DONE_LIMIT   = 1000;
    localparam int RESULT_LIMIT = (RESP_GAP_BITS + RESP_TIMEOUT_BITS + CMD_BITS) * SD_CLK_DIV;
    localparam int SILENT_LIMIT = (RESP_GAP_BITS + RESP_TIMEOUT_BITS) * SD_CLK_DIV;

    logic         clk_fast;
    logic         init_resetPulse;
    logic         cmd_valid;
    cmd_req_t     cmd_req;
    logic         cmd_ready;
    logic         cmd_done;
    logic         resp_valid;
    resp_result_t resp_result;
    logic         sd_clk;
    logic         sd_cmd_out;
    logic         sd_cmd_oe;
    logic         sd_cmd_in;
    logic         card_out;
    logic         card_oe;
    int           cmd_count;
    cmd_index_t   cap_index;
    cmd_arg_t     cap_arg;
    logic         token_ok;
    fault_t       fault;
    resp_result_t expected_q[$];
    time          last_rise;

    // Open drain style line, idle high
    assign sd_cmd_in = sd_cmd_oe ? sd_cmd_out : (card_oe ? card_out : 1'b1);

    sd_cmd_host uut (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_valid       (cmd_valid),
        .cmd_req         (cmd_req),
        .cmd_ready       (cmd_ready),
        .cmd_done        (cmd_done),
        .resp_valid      (resp_valid),
        .resp_result     (resp_result),
        .sd_clk          (sd_clk),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .sd_cmd_in       (sd_cmd_in)
    );

    sd_card_model card (
        .sd_clk      (sd_clk),
        .cmd_line    (sd_cmd_in),
        .corrupt_crc (fault == CORRUPT_CRC),
        .bad_end     (fault == BAD_END),
        .silent      (fault == SILENT),
        .card_out    (card_out),
        .card_oe     (card_oe),
        .cmd_count   (cmd_count),
        .cap_index   (cap_index),
        .cap_arg     (cap_arg),
        .token_ok    (token_ok)
    );

    initial begin
        clk_fast = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_fast = ~clk_fast;
    end

    // ====================
    // Reference and checks
    // ====================
    function automatic resp_result_t expected_result(input cmd_req_t req, input fault_t f);
        resp_result_t r;
        r = '0;
        if (f == SILENT) begin
            r.timeout = 1'b1;
        end else begin
            r.index   = req.index;
            r.arg     = ~req.arg;
            r.crc_err = (f == CORRUPT_CRC);
            r.end_err = (f == BAD_END);
        end
        return r;
    endfunction

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        fail_run();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_period(input string name, input time got, input time exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d ns, expected %0d ns", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_result(input string name, input resp_result_t got,
                                input resp_result_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_command(input cmd_index_t got_index, input cmd_arg_t got_arg,
                                 input cmd_index_t exp_index, input cmd_arg_t exp_arg);
        if (got_index !== exp_index) begin
            $display("** Error at %0t ns: card index = %h, expected %h",
                     $time, got_index, exp_index);
            fail_run();
        end
        if (got_arg !== exp_arg) begin
            $display("** Error at %0t ns: card arg = %h, expected %h", $time, got_arg, exp_arg);
            fail_run();
        end
    endtask

    // Called at a falling edge, returns at the falling edge that shows cmd_done
    task automatic send_command(input cmd_req_t req, input fault_t f);
        int count_before;
        int cycles;
        count_before = cmd_count;
        fault        = f;
        cmd_req      = req;
        cmd_valid    = 1'b1;
        cycles       = 0;
        while (!cmd_ready) begin
            @(negedge clk_fast);
            cycles++;
            if (cycles > READY_LIMIT) report_timeout("cmd_ready");
        end
        if (req.resp_kind == RESP_48) begin
            expected_q.push_back(expected_result(req, f));
        end
        @(negedge clk_fast);
        cmd_valid = 1'b0;
        cmd_req   = '0;
        check_flag("cmd_ready after acceptance", cmd_ready, 1'b0);
        cycles    = 0;
        while (!cmd_done) begin
            @(negedge clk_fast);
            cycles++;
            if (cycles > DONE_LIMIT) report_timeout("cmd_done");
        end
        // A pending response keeps the port closed past cmd_done
        check_flag("cmd_ready at cmd_done", cmd_ready, req.resp_kind == RESP_NONE);
        check_flag("card token_ok", token_ok, 1'b1);
        check_flag("card saw one new command", cmd_count == count_before + 1, 1'b1);
        check_command(cap_index, cap_arg, req.index, req.arg);
    endtask

    task automatic wait_result(input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_fast);
            cycles++;
            if (cycles > limit) report_timeout("resp_valid");
        end while (!resp_valid);
    endtask

    // Every response is compared against the oldest pending request
    always @(negedge clk_fast) begin
        if (!init_resetPulse && resp_valid) begin
            if (expected_q.size() == 0) begin
                $display("resp_valid at %0t ns with no response pending", $time);
                fail_run();
            end else begin
                check_result("resp_result", resp_result, expected_q.pop_front());
            end
        end
    end

    always @(negedge clk_fast) begin
        if (!init_resetPulse) begin
            check_flag("sd_cmd_oe && card_oe", sd_cmd_oe && card_oe, 1'b0);
        end
    end

    // sd_clk rises once every SD_CLK_DIV clk_fast cycles
    always @(posedge sd_clk) begin
        if (last_rise != 0) begin
            check_period("sd_clk period", $time - last_rise, SD_CLK_DIV * CLK_PERIOD_NS);
        end
        last_rise = $time;
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        cmd_req_t req;
        fault_t   f;
        int       cycles;
        int       n;
        $timeformat(-9, 0, "", 0);
        void'($urandom(50235));
        last_rise       = 0;
        init_resetPulse = 1'b1;
        cmd_valid       = 1'b0;
        cmd_req         = '0;
        fault           = FAULT_NONE;
        repeat (5) @(negedge clk_fast);
        init_resetPulse = 1'b0;
        @(negedge clk_fast);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("cmd_done", cmd_done, 1'b0);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("sd_clk", sd_clk, 1'b0);
        check_flag("sd_cmd_oe", sd_cmd_oe, 1'b0);
        check_flag("sd_cmd_out", sd_cmd_out, 1'b1);

        // No response expected, the compare process flags any resp_valid
        req = '{index: 6'd0, arg: 32'h0000_0000, resp_kind: RESP_NONE};
        send_command(req, SILENT);
        repeat (SILENT_LIMIT + 4 * SD_CLK_DIV) @(negedge clk_fast);

        req = '{index: 6'd17, arg: 32'h1234_5678, resp_kind: RESP_48};
        send_command(req, FAULT_NONE);
        wait_result(RESULT_LIMIT, cycles);
        req = '{index: 6'd55, arg: 32'hdead_beef, resp_kind: RESP_48};
        send_command(req, CORRUPT_CRC);
        wait_result(RESULT_LIMIT, cycles);
        req = '{index: 6'd8, arg: 32'h0000_01aa, resp_kind: RESP_48};
        send_command(req, BAD_END);
        wait_result(RESULT_LIMIT, cycles);
        req = '{index: 6'd2, arg: 32'hffff_0000, resp_kind: RESP_48};
        send_command(req, SILENT);
        wait_result(RESULT_LIMIT, cycles);
        check_flag("timeout inside gap and wait window", cycles <= SILENT_LIMIT, 1'b1);

        // Back to back, the next request waits on cmd_ready
        for (n = 0; n < 20; n++) begin
            repeat ($urandom_range(3, 0)) @(negedge clk_fast);
            req.index     = cmd_index_t'($urandom);
            req.arg       = $urandom;
            req.resp_kind = resp_kind_t'($urandom_range(1, 0));
            f = (req.resp_kind == RESP_48) ? fault_t'($urandom_range(3, 0)) : SILENT;
            send_command(req, f);
        end

        cycles = 0;
        while (expected_q.size() != 0 && cycles <= RESULT_LIMIT) begin
            @(negedge clk_fast);
            cycles++;
        end
        if (expected_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d responses never arrived", expected_q.size());
            fail_run();
        end
    end

endmodule
